//--- build.f
common/bus_pkg.sv
common/soc_map_pkg.sv
src/dmem.sv
src/cpu_bus_master.sv
uart/uart_wb_regs.sv
uart/uart_tx.sv
src/bus_soc_top.sv
bench/bus_soc_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module bus_soc_tb -f build.f &&
  ./obj_dir/Vbus_soc_tb | grep "SIMULATION PASSED" ||
  { echo "Simulation did not pass"; exit 1; }

//--- bench/bus_soc_tb.sv
`timescale 1ns/10ps

module bus_soc_tb;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int BIT_CYCLES     = soc_map_pkg::CLKS_PER_BIT;
  localparam int FRAME_CYCLES   = 10 * BIT_CYCLES;
  localparam int TX_START_CYCLE = 2; // tx_start pulses together with the Wishbone ack

  logic        CLK_I;
  logic        rst_i;
  logic        mem_valid_i;
  logic        mem_wen_i;
  logic [31:0] mem_addr_i;
  logic [31:0] mem_wdata_i;
  logic [3:0]  mem_strb_i;
  logic [31:0] mem_rdata_o;
  logic        mem_done_o;
  logic        mem_err_o;
  logic        uart_txd_o;

  // Expected response of the access in flight
  int          exp_lat;
  logic        exp_err;
  logic        chk_rdata;
  logic [31:0] exp_rdata;
  logic        exp_tx;
  logic [7:0]  exp_byte;

  logic        in_flight;
  int          wait_cycles;
  int          cycle_count;

  // Expected serial line
  logic        line_busy;
  int          line_cnt;
  logic [9:0]  line_frame;
  logic        exp_txd;

  logic [7:0]  ref_mem [0:soc_map_pkg::DMEM_WORDS*4-1];
  logic [9:0]  words [8];
  integer      seed;
  logic [31:0] rnd;
  logic [31:0] data;

  bus_soc_top UUT (
    .CLK_I       (CLK_I),
    .rst_i       (rst_i),
    .mem_valid_i (mem_valid_i),
    .mem_wen_i   (mem_wen_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_strb_i  (mem_strb_i),
    .mem_rdata_o (mem_rdata_o),
    .mem_done_o  (mem_done_o),
    .mem_err_o   (mem_err_o),
    .uart_txd_o  (uart_txd_o)
  );

  initial begin
    CLK_I = 1'b0;
    forever #2 CLK_I = ~CLK_I;
  end

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    $display("Fail t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] ref_read(input logic [9:0] word);
    logic [31:0] value;
    for (int b = 0; b < 4; b++) begin
      value[b*8 +: 8] = ref_mem[word*4 + b];
    end
    return value;
  endfunction

  task automatic ref_write(input logic [9:0] word, input logic [31:0] wdata,
                           input logic [3:0] strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) ref_mem[word*4 + b] = wdata[b*8 +: 8];
    end
  endtask

  function automatic logic [31:0] dmem_addr(input logic [9:0] word);
    return {soc_map_pkg::REGION_DMEM, 4'h0, word, 2'b00};
  endfunction

  function automatic logic [31:0] uart_addr(input logic [3:0] ofs);
    return {soc_map_pkg::REGION_UART, 12'h000, ofs};
  endfunction

  // One strobe, optionally followed by a second one that the busy master must drop
  task automatic cpu_access(input logic wen, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input int lat, input logic err,
                            input logic chk, input logic [31:0] rdata, input logic tx,
                            input logic ghost);
    @(negedge CLK_I);
    exp_lat     = lat;
    exp_err     = err;
    chk_rdata   = chk;
    exp_rdata   = rdata;
    exp_tx      = tx;
    exp_byte    = wdata[7:0];
    mem_valid_i = 1'b1;
    mem_wen_i   = wen;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_strb_i  = strb;
    @(negedge CLK_I);
    mem_valid_i = ghost;
    mem_wdata_i = ~wdata;
    if (ghost) begin
      @(negedge CLK_I);
      mem_valid_i = 1'b0;
    end
    while (!mem_done_o) @(negedge CLK_I);
  endtask

  always @(posedge CLK_I) begin
    if (rst_i) begin
      in_flight   <= 1'b0;
      wait_cycles <= 0;
    end else if (!in_flight && mem_valid_i) begin
      in_flight   <= 1'b1;
      wait_cycles <= 1;
    end else if (in_flight) begin
      wait_cycles <= wait_cycles + 1;
      if (mem_done_o) in_flight <= 1'b0;
    end
  end

  always @(posedge CLK_I) begin
    if (rst_i) begin
      line_busy <= 1'b0;
      line_cnt  <= 0;
    end else if (in_flight && wait_cycles == TX_START_CYCLE && exp_tx) begin
      line_busy  <= 1'b1;
      line_cnt   <= 0;
      line_frame <= {1'b1, exp_byte, 1'b0}; // Stop, data LSB first, start
    end else if (line_busy) begin
      if (line_cnt == FRAME_CYCLES - 1) line_busy <= 1'b0;
      else line_cnt <= line_cnt + 1;
    end
  end

  assign exp_txd = line_busy ? line_frame[line_cnt / BIT_CYCLES] : 1'b1;

  always @(posedge CLK_I) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  reset_values: assert property (@(posedge CLK_I)
    rst_i |=> !mem_done_o && !mem_err_o && uart_txd_o)
    else report_value("mem_done_o,mem_err_o,uart_txd_o", 32'h1,
                      {29'h0, $sampled(mem_done_o), $sampled(mem_err_o), $sampled(uart_txd_o)});

  done_expected: assert property (@(posedge CLK_I) disable iff (rst_i)
    mem_done_o |-> in_flight && wait_cycles == exp_lat)
    else report_value("mem_done_o latency", exp_lat, $sampled(wait_cycles));

  done_missing: assert property (@(posedge CLK_I) disable iff (rst_i)
    in_flight && wait_cycles == exp_lat |-> mem_done_o)
    else report_value("mem_done_o", 32'd1, 32'd0);

  done_pulse: assert property (@(posedge CLK_I) disable iff (rst_i) mem_done_o |=> !mem_done_o)
    else report_value("mem_done_o", 32'd0, 32'd1);

  err_value: assert property (@(posedge CLK_I) disable iff (rst_i)
    mem_done_o |-> mem_err_o == exp_err)
    else report_value("mem_err_o", 32'(exp_err), 32'($sampled(mem_err_o)));

  err_idle: assert property (@(posedge CLK_I) disable iff (rst_i) !mem_done_o |-> !mem_err_o)
    else report_value("mem_err_o", 32'd0, 32'd1);

  rdata_value: assert property (@(posedge CLK_I) disable iff (rst_i)
    mem_done_o && chk_rdata |-> mem_rdata_o == exp_rdata)
    else report_value("mem_rdata_o", exp_rdata, $sampled(mem_rdata_o));

  txd_value: assert property (@(posedge CLK_I) disable iff (rst_i) uart_txd_o == exp_txd)
    else report_value("uart_txd_o", 32'($sampled(exp_txd)), 32'($sampled(uart_txd_o)));

  initial begin
    seed        = 1294;
    cycle_count = 0;
    rst_i       = 1'b1;
    mem_valid_i = 1'b0;
    mem_wen_i   = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_strb_i  = '0;
    exp_lat     = 0;
    exp_err     = 1'b0;
    chk_rdata   = 1'b0;
    exp_rdata   = '0;
    exp_tx      = 1'b0;
    exp_byte    = '0;
    repeat (16) @(posedge CLK_I);
    @(negedge CLK_I);
    rst_i = 1'b0;

    // Full words first, so that every later read hits written bytes
    for (int i = 0; i < 8; i++) begin
      rnd      = $random(seed);
      words[i] = rnd[9:0];
      data     = $random(seed);
      ref_write(words[i], data, 4'hF);
      cpu_access(1'b1, dmem_addr(words[i]), data, 4'hF, 2, 1'b0, 1'b0, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      ref_write(words[rnd[6:4]], data, rnd[3:0]);
      cpu_access(1'b1, dmem_addr(words[rnd[6:4]]), data, rnd[3:0], 2, 1'b0, 1'b0, '0,
                 1'b0, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      cpu_access(1'b0, dmem_addr(words[i]), '0, '0, 2, 1'b0, 1'b1, ref_read(words[i]),
                 1'b0, 1'b0);
    end

    // A second strobe during the access must neither complete nor write
    data = $random(seed);
    ref_write(words[0], data, 4'hF);
    cpu_access(1'b1, dmem_addr(words[0]), data, 4'hF, 2, 1'b0, 1'b0, '0, 1'b0, 1'b1);
    repeat (4) @(negedge CLK_I);
    cpu_access(1'b0, dmem_addr(words[0]), '0, '0, 2, 1'b0, 1'b1, ref_read(words[0]),
               1'b0, 1'b0);

    cpu_access(1'b0, 32'h0200_0040, '0, '0, 2, 1'b1, 1'b1, '0, 1'b0, 1'b0);
    cpu_access(1'b1, 32'h0000_0010, 32'h1234_5678, 4'hF, 2, 1'b1, 1'b1, '0, 1'b0, 1'b0);

    for (int f = 0; f < 3; f++) begin
      rnd = $random(seed);
      cpu_access(1'b1, uart_addr(soc_map_pkg::UART_TXDATA_OFS), {24'h0, rnd[7:0]}, 4'h1,
                 3, 1'b0, 1'b0, '0, 1'b1, 1'b0);
      if (f == 0) begin
        cpu_access(1'b0, uart_addr(soc_map_pkg::UART_STATUS_OFS), '0, '0, 3, 1'b0, 1'b1,
                   32'd1, 1'b0, 1'b0);
        cpu_access(1'b1, uart_addr(soc_map_pkg::UART_TXDATA_OFS), 32'h0000_005A, 4'h1,
                   3, 1'b1, 1'b0, '0, 1'b0, 1'b0);
        cpu_access(1'b1, uart_addr(soc_map_pkg::UART_STATUS_OFS), 32'h0000_0001, 4'hF,
                   3, 1'b1, 1'b0, '0, 1'b0, 1'b0);
        cpu_access(1'b0, uart_addr(4'h8), '0, '0, 3, 1'b1, 1'b0, '0, 1'b0, 1'b0);
      end
      while (line_busy) @(negedge CLK_I);
      cpu_access(1'b0, uart_addr(soc_map_pkg::UART_STATUS_OFS), '0, '0, 3, 1'b0, 1'b1,
                 32'd0, 1'b0, 1'b0);
    end

    repeat (4) @(negedge CLK_I);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- src/bus_soc_top.sv
`timescale 1ns/10ps

module bus_soc_top (
  input  logic                       CLK_I,
  input  logic                       rst_i,
  input  logic                       mem_valid_i,
  input  logic                       mem_wen_i,
  input  logic [bus_pkg::ADDR_W-1:0] mem_addr_i,
  input  logic [bus_pkg::DATA_W-1:0] mem_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] mem_strb_i,
  output logic [bus_pkg::DATA_W-1:0] mem_rdata_o,
  output logic                       mem_done_o,
  output logic                       mem_err_o,
  output logic                       uart_txd_o
);

  logic                       wb_cyc;
  logic                       wb_stb;
  logic [bus_pkg::ADDR_W-1:0] wb_adr;
  logic                       wb_we;
  logic [bus_pkg::DATA_W-1:0] wb_dat_m2s;
  logic [bus_pkg::STRB_W-1:0] wb_sel;
  logic [bus_pkg::DATA_W-1:0] wb_dat_s2m;
  logic                       wb_ack;
  logic                       wb_err;

  logic [bus_pkg::ADDR_W-1:0] dmem_addr;
  logic                       dmem_en;
  logic                       dmem_wen;
  logic [bus_pkg::DATA_W-1:0] dmem_wdata;
  logic [bus_pkg::STRB_W-1:0] dmem_wstrb;
  logic [bus_pkg::DATA_W-1:0] dmem_rdata;

  logic       tx_start;
  logic [7:0] tx_data;
  logic       tx_busy;

  cpu_bus_master u_master (
    .CLK_I        (CLK_I),
    .rst_i        (rst_i),
    .mem_valid_i  (mem_valid_i),
    .mem_wen_i    (mem_wen_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_strb_i   (mem_strb_i),
    .mem_rdata_o  (mem_rdata_o),
    .mem_done_o   (mem_done_o),
    .mem_err_o    (mem_err_o),
    .wbm_dat_i    (wb_dat_s2m),
    .wbm_ack_i    (wb_ack),
    .wbm_err_i    (wb_err),
    .wbm_cyc_o    (wb_cyc),
    .wbm_stb_o    (wb_stb),
    .wbm_adr_o    (wb_adr),
    .wbm_we_o     (wb_we),
    .wbm_dat_o    (wb_dat_m2s),
    .wbm_sel_o    (wb_sel),
    .dmem_rdata_i (dmem_rdata),
    .dmem_addr_o  (dmem_addr),
    .dmem_en_o    (dmem_en),
    .dmem_wen_o   (dmem_wen),
    .dmem_wdata_o (dmem_wdata),
    .dmem_wstrb_o (dmem_wstrb)
  );

  dmem u_dmem (
    .CLK_I   (CLK_I),
    .en_i    (dmem_en),
    .wen_i   (dmem_wen),
    .addr_i  (dmem_addr),
    .wdata_i (dmem_wdata),
    .wstrb_i (dmem_wstrb),
    .rdata_o (dmem_rdata)
  );

  uart_wb_regs u_uart_regs (
    .CLK_I      (CLK_I),
    .rst_i      (rst_i),
    .wbs_cyc_i  (wb_cyc),
    .wbs_stb_i  (wb_stb),
    .wbs_adr_i  (wb_adr),
    .wbs_we_i   (wb_we),
    .wbs_dat_i  (wb_dat_m2s),
    .wbs_sel_i  (wb_sel),
    .wbs_dat_o  (wb_dat_s2m),
    .wbs_ack_o  (wb_ack),
    .wbs_err_o  (wb_err),
    .tx_busy_i  (tx_busy),
    .tx_start_o (tx_start),
    .tx_data_o  (tx_data)
  );

  uart_tx u_uart_tx (
    .CLK_I   (CLK_I),
    .rst_i   (rst_i),
    .start_i (tx_start),
    .data_i  (tx_data),
    .busy_o  (tx_busy),
    .txd_o   (uart_txd_o)
  );

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
  input  logic       CLK_I,
  input  logic       rst_i,
  input  logic       start_i,
  input  logic [7:0] data_i,
  output logic       busy_o,
  output logic       txd_o
);

  logic [$clog2(soc_map_pkg::CLKS_PER_BIT)-1:0] baud_cnt_q;
  logic [3:0]                                   bit_cnt_q;
  logic [8:0]                                   frame_q;
  logic                                         bit_end;

  assign bit_end = (baud_cnt_q ==
                    ($clog2(soc_map_pkg::CLKS_PER_BIT))'(soc_map_pkg::CLKS_PER_BIT - 1));

  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      busy_o     <= 1'b0;
      txd_o      <= 1'b1; // Line idles high
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!busy_o) begin
      if (start_i) begin
        busy_o     <= 1'b1;
        txd_o      <= 1'b0; // Start bit
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
      end
    end else begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
      if (bit_end) begin
        baud_cnt_q <= '0;
        if (bit_cnt_q == 4'd9) begin
          busy_o <= 1'b0; // Stop bit has ended
          txd_o  <= 1'b1;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          txd_o     <= frame_q[0];
        end
      end
    end
  end

  // Stop and data LSB first, shifted toward bit 0
  always_ff @(posedge CLK_I) begin
    if (!busy_o && start_i) begin
      frame_q <= {1'b1, data_i};
    end else if (busy_o && bit_end) begin
      frame_q <= {1'b1, frame_q[8:1]};
    end
  end

endmodule

//--- uart/uart_wb_regs.sv
`timescale 1ns/10ps

module uart_wb_regs (
  input  logic                       CLK_I,
  input  logic                       rst_i,

  input  logic                       wbs_cyc_i,
  input  logic                       wbs_stb_i,
  input  logic [bus_pkg::ADDR_W-1:0] wbs_adr_i,
  input  logic                       wbs_we_i,
  input  logic [bus_pkg::DATA_W-1:0] wbs_dat_i,
  input  logic [bus_pkg::STRB_W-1:0] wbs_sel_i,
  output logic [bus_pkg::DATA_W-1:0] wbs_dat_o,
  output logic                       wbs_ack_o,
  output logic                       wbs_err_o,

  input  logic                       tx_busy_i,
  output logic                       tx_start_o,
  output logic [7:0]                 tx_data_o
);

  logic req;
  logic ofs_high_zero;
  logic hit_txdata;
  logic hit_status;
  logic wr_tx;
  logic rd_status;
  logic access_ok;

  assign req           = wbs_cyc_i && wbs_stb_i;
  assign ofs_high_zero = (wbs_adr_i[15:4] == '0); // Offsets above the register block are unmapped
  assign hit_txdata    = ofs_high_zero && (wbs_adr_i[3:0] == soc_map_pkg::UART_TXDATA_OFS);
  assign hit_status    = ofs_high_zero && (wbs_adr_i[3:0] == soc_map_pkg::UART_STATUS_OFS);

  // Only a TXDATA write into an idle transmitter or a STATUS read succeeds
  assign wr_tx     = hit_txdata && wbs_we_i && wbs_sel_i[0] && !tx_busy_i;
  assign rd_status = hit_status && !wbs_we_i;
  assign access_ok = wr_tx || rd_status;

  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      wbs_ack_o  <= 1'b0;
      wbs_err_o  <= 1'b0;
      tx_start_o <= 1'b0;
    end else begin
      wbs_ack_o  <= req && access_ok;
      wbs_err_o  <= req && !access_ok;
      tx_start_o <= req && wr_tx;
    end
  end

  always_ff @(posedge CLK_I) begin
    if (req && wr_tx) begin
      tx_data_o <= wbs_dat_i[7:0];
    end
    wbs_dat_o <= (req && rd_status) ? {{(bus_pkg::DATA_W-1){1'b0}}, tx_busy_i} : '0;
  end

endmodule

//--- src/cpu_bus_master.sv
`timescale 1ns/10ps

module cpu_bus_master (
  input  logic                        CLK_I,
  input  logic                        rst_i,

  input  logic                        mem_valid_i,
  input  logic                        mem_wen_i,
  input  logic [bus_pkg::ADDR_W-1:0]  mem_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]  mem_wdata_i,
  input  logic [bus_pkg::STRB_W-1:0]  mem_strb_i,
  output logic [bus_pkg::DATA_W-1:0]  mem_rdata_o,
  output logic                        mem_done_o,
  output logic                        mem_err_o,

  input  logic [bus_pkg::DATA_W-1:0]  wbm_dat_i,
  input  logic                        wbm_ack_i,
  input  logic                        wbm_err_i,
  output logic                        wbm_cyc_o,
  output logic                        wbm_stb_o,
  output logic [bus_pkg::ADDR_W-1:0]  wbm_adr_o,
  output logic                        wbm_we_o,
  output logic [bus_pkg::DATA_W-1:0]  wbm_dat_o,
  output logic [bus_pkg::STRB_W-1:0]  wbm_sel_o,

  input  logic [bus_pkg::DATA_W-1:0]  dmem_rdata_i,
  output logic [bus_pkg::ADDR_W-1:0]  dmem_addr_o,
  output logic                        dmem_en_o,
  output logic                        dmem_wen_o,
  output logic [bus_pkg::DATA_W-1:0]  dmem_wdata_o,
  output logic [bus_pkg::STRB_W-1:0]  dmem_wstrb_o
);

  bus_pkg::master_state_t state_q;

  logic [bus_pkg::ADDR_W-1:0] req_addr_q;
  logic [bus_pkg::DATA_W-1:0] req_wdata_q;
  logic [bus_pkg::STRB_W-1:0] req_strb_q;
  logic                       req_wen_q;

  logic [15:0] region;
  logic        dmem_hit;
  logic        uart_hit;
  logic        accept;
  logic        wb_resp;

  assign region   = mem_addr_i[bus_pkg::ADDR_W-1 -: 16];
  assign dmem_hit = (region == soc_map_pkg::REGION_DMEM);
  assign uart_hit = (region == soc_map_pkg::REGION_UART);
  assign accept   = (state_q == bus_pkg::IDLE) && mem_valid_i; // Strobes while busy are dropped
  assign wb_resp  = wbm_ack_i || wbm_err_i;

  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      state_q    <= bus_pkg::IDLE;
      mem_done_o <= 1'b0;
      mem_err_o  <= 1'b0;
      dmem_en_o  <= 1'b0;
      wbm_cyc_o  <= 1'b0;
      wbm_stb_o  <= 1'b0;
    end else begin
      mem_done_o <= 1'b0;
      mem_err_o  <= 1'b0;
      case (state_q)
        bus_pkg::IDLE: begin
          if (accept) begin
            if (dmem_hit) begin
              dmem_en_o <= 1'b1;
              state_q   <= bus_pkg::DMEM_WAIT;
            end else if (uart_hit) begin
              wbm_cyc_o <= 1'b1;
              wbm_stb_o <= 1'b1;
              state_q   <= bus_pkg::WB_WAIT;
            end else begin
              state_q <= bus_pkg::UNMAPPED_WAIT;
            end
          end
        end
        bus_pkg::DMEM_WAIT: begin
          dmem_en_o  <= 1'b0; // Memory access always takes one cycle
          mem_done_o <= 1'b1;
          state_q    <= bus_pkg::IDLE;
        end
        bus_pkg::WB_WAIT: begin
          wbm_stb_o <= 1'b0;
          if (wb_resp) begin
            wbm_cyc_o  <= 1'b0;
            mem_done_o <= 1'b1;
            mem_err_o  <= wbm_err_i;
            state_q    <= bus_pkg::IDLE;
          end
        end
        bus_pkg::UNMAPPED_WAIT: begin
          mem_done_o <= 1'b1;
          mem_err_o  <= 1'b1;
          state_q    <= bus_pkg::IDLE;
        end
        default: state_q <= bus_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_I) begin
    if (accept) begin
      req_addr_q  <= mem_addr_i;
      req_wdata_q <= mem_wdata_i;
      req_strb_q  <= mem_strb_i;
      req_wen_q   <= mem_wen_i;
    end
    case (state_q)
      bus_pkg::DMEM_WAIT:     mem_rdata_o <= dmem_rdata_i;
      bus_pkg::WB_WAIT:       if (wb_resp) mem_rdata_o <= wbm_dat_i;
      bus_pkg::UNMAPPED_WAIT: mem_rdata_o <= '0;
      default: ;
    endcase
  end

  // Both targets see the captured request and qualify it with their own enable
  assign dmem_addr_o  = req_addr_q;
  assign dmem_wen_o   = req_wen_q;
  assign dmem_wdata_o = req_wdata_q;
  assign dmem_wstrb_o = req_strb_q;
  assign wbm_adr_o    = req_addr_q;
  assign wbm_we_o     = req_wen_q;
  assign wbm_dat_o    = req_wdata_q;
  assign wbm_sel_o    = req_strb_q;

endmodule

//--- src/dmem.sv
`timescale 1ns/10ps

module dmem (
  input  logic                       CLK_I,
  input  logic                       en_i,
  input  logic                       wen_i,
  input  logic [bus_pkg::ADDR_W-1:0] addr_i,
  input  logic [bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::STRB_W-1:0] wstrb_i,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);

  logic [bus_pkg::DATA_W-1:0] mem [soc_map_pkg::DMEM_WORDS];
  logic [$clog2(soc_map_pkg::DMEM_WORDS)-1:0] word_idx;

  assign word_idx = addr_i[$clog2(soc_map_pkg::DMEM_WORDS)+1:2]; // Byte address to word index

  always_ff @(posedge CLK_I) begin
    if (en_i && wen_i) begin
      for (int lane = 0; lane < bus_pkg::STRB_W; lane++) begin
        if (wstrb_i[lane]) begin
          mem[word_idx][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
        end
      end
    end
  end

  assign rdata_o = mem[word_idx];

endmodule

//--- common/soc_map_pkg.sv
package soc_map_pkg;

  // Address bits 31..16 select the target
  localparam logic [15:0] REGION_DMEM = 16'h0010;
  localparam logic [15:0] REGION_UART = 16'h0100;

  // Data memory depth in 32-bit words
  localparam int unsigned DMEM_WORDS = 1024;

  // UART register byte offsets
  localparam logic [3:0] UART_TXDATA_OFS = 4'h0;
  localparam logic [3:0] UART_STATUS_OFS = 4'h4; // Bit 0 reads back the transmitter busy flag

  // Serial bit period in clock cycles
  localparam int unsigned CLKS_PER_BIT = 8;

endpackage

//--- common/bus_pkg.sv
package bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = 4; // One strobe per byte lane

  typedef enum logic [1:0] {
    IDLE,
    WB_WAIT,
    DMEM_WAIT,
    UNMAPPED_WAIT
  } master_state_t;

endpackage
